// ==== list.f ====
+incdir+src
src/vga_pkg.sv
src/pixel_timing.sv
src/digit_sprite.sv
src/pixel_color.sv
src/scoreboard_top.sv
tb/scoreboard_asserts.sv
tb/scoreboard_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run with Verilator, the log decides pass or fail
rm -f sim.log
verilator --binary --timing --assert --top-module scoreboard_tb -f list.f \
   && ./obj_dir/Vscoreboard_tb > sim.log 2>&1 \
   || echo "build or simulation error" >> sim.log
cat sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0

// ==== tb/scoreboard_tb.sv ====
`timescale 1ns/1ps

`include "vga_macros.svh"

module scoreboard_tb
   import vga_pkg::*;
();

   // ----------------------------------------------------------------------
   // run geometry
   // ----------------------------------------------------------------------
   localparam int CLK_PERIOD   = 40;
   localparam int PIPE         = `PIPE_DEPTH;
   localparam int H_VIS        = int'(`H_VISIBLE);
   localparam int H_FP         = int'(`H_FRONT);
   localparam int H_SY         = int'(`H_SYNC);
   localparam int H_TOTAL      = H_VIS + H_FP + H_SY + int'(`H_BACK);
   localparam int V_VIS        = int'(`V_VISIBLE);
   localparam int V_FP         = int'(`V_FRONT);
   localparam int V_SY         = int'(`V_SYNC);
   localparam int V_TOTAL      = V_VIS + V_FP + V_SY + int'(`V_BACK);
   localparam int SPR_X        = int'(`SPRITE_X);
   localparam int SPR_Y        = int'(`SPRITE_Y);
   localparam int SPR_W        = int'(`SPRITE_W);
   localparam int SPR_H        = int'(`SPRITE_H);
   localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
   // counter index of the refresh tick inside a frame
   localparam int TICK_INDEX   = V_VIS * H_TOTAL;
   localparam int NUM_FRAMES   = 4;
   // one spare frame on top of the run
   localparam int WATCHDOG_NS  = (NUM_FRAMES + 1) * FRAME_CYCLES * CLK_PERIOD;

   logic   clk = 1'b0;
   logic   reset;
   digit_e digit_sel;
   rgb_t   rgb;
   logic   hsync;
   logic   vsync;

   integer seed;
   int     cycle_cnt = 0;
   int     cur_x = -1;
   int     cur_y = -1;
   int     test_checks = 0;
   int     test_errors = 0;
   int     total_checks = 0;
   int     total_errors = 0;
   logic   run_done = 1'b0;
   // digit sampled at each refresh tick, one entry per frame
   digit_e tick_digit[$];

   scoreboard_top dut
   (
      .clk       (clk),
      .reset     (reset),
      .digit_sel (digit_sel),
      .rgb       (rgb),
      .hsync     (hsync),
      .vsync     (vsync)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // ----------------------------------------------------------------------
   // reference model
   // ----------------------------------------------------------------------
   // seven segment glyph, 16 rows by 32 columns
   function automatic logic glyph_bit(input digit_e digit, input int row, input int col);
      logic [6:0] segs;
      logic       bar;
      logic       left;
      logic       right;
      // usual a to g order, a in bit 6
      case (digit)
         digit_zero:  segs = 7'b1111110;
         digit_one:   segs = 7'b0110000;
         digit_two:   segs = 7'b1101101;
         digit_three: segs = 7'b1111001;
         digit_four:  segs = 7'b0110011;
         digit_five:  segs = 7'b1011011;
         digit_six:   segs = 7'b1011111;
         digit_seven: segs = 7'b1110000;
         digit_eight: segs = 7'b1111111;
         digit_nine:  segs = 7'b1111011;
         default:     segs = 7'b0000000;
      endcase
      bar   = (col >= 8) && (col <= 23);
      left  = (col >= 8) && (col <= 11);
      right = (col >= 20) && (col <= 23);
      // top bar, upper strokes, middle bar, lower strokes, bottom bar
      if (row < 2)
         return (segs[6] && bar) || (segs[1] && left) || (segs[5] && right);
      else if (row < 7)
         return (segs[1] && left) || (segs[5] && right);
      else if (row < 9)
         return (segs[0] && bar) || ((segs[1] || segs[2]) && left) ||
                ((segs[5] || segs[4]) && right);
      else if (row < 14)
         return (segs[2] && left) || (segs[4] && right);
      else
         return (segs[3] && bar) || (segs[2] && left) || (segs[4] && right);
   endfunction

   function automatic rgb_t expected_rgb(input int x, input int y, input digit_e digit);
      int row;
      int col;
      // blanking first
      if (x >= H_VIS || y >= V_VIS)
         return rgb_t'(3'b000);
      if (x < SPR_X || x >= SPR_X + SPR_W || y < SPR_Y || y >= SPR_Y + SPR_H)
         return rgb_t'(`BG_RGB);
      row = y - SPR_Y;
      col = x - SPR_X;
      if (glyph_bit(digit, row, col))
         return rgb_t'(`SPRITE_RGB);
      else
         return rgb_t'(`BG_RGB);
   endfunction

   // syncs are active low
   function automatic logic expected_hsync(input int x);
      return !((x >= H_VIS + H_FP) && (x < H_VIS + H_FP + H_SY));
   endfunction

   function automatic logic expected_vsync(input int y);
      return !((y >= V_VIS + V_FP) && (y < V_VIS + V_FP + V_SY));
   endfunction

   // ----------------------------------------------------------------------
   // compare tasks
   // ----------------------------------------------------------------------
   task automatic check_rgb(input rgb_t got, input rgb_t exp, input string name);
      test_checks++;
      total_checks++;
      if (got !== exp)
      begin
         test_errors++;
         total_errors++;
         $display("[FAIL] time %0t %s at x=%0d y=%0d got %b expected %b",
                  $time, name, cur_x, cur_y, got, exp);
      end
   endtask

   task automatic check_sync(input logic got, input logic exp, input string name);
      test_checks++;
      total_checks++;
      if (got !== exp)
      begin
         test_errors++;
         total_errors++;
         $display("[FAIL] time %0t %s at x=%0d y=%0d got %b expected %b",
                  $time, name, cur_x, cur_y, got, exp);
      end
   endtask

   task automatic finish_test(input string name);
      $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
   endtask

   // ----------------------------------------------------------------------
   // cycle count and digit model
   // ----------------------------------------------------------------------
   // cycle_cnt equals the scan index the counters show
   always @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         cycle_cnt <= 0;
      end
      else
      begin
         if ((cycle_cnt % FRAME_CYCLES) == TICK_INDEX)
            tick_digit.push_back(digit_sel);
         cycle_cnt <= cycle_cnt + 1;
      end
   end

   // outputs sampled mid cycle, lagging the counters by PIPE
   always @(negedge clk)
   begin : compare_outputs
      int     p;
      int     frame;
      digit_e shown;
      if (!run_done)
      begin
         if (reset || cycle_cnt < PIPE)
         begin
            // idle levels until the pipeline fills
            check_rgb(rgb, rgb_t'(3'b000), "rgb");
            check_sync(hsync, 1'b1, "hsync");
            check_sync(vsync, 1'b1, "vsync");
            if (!reset && cycle_cnt == PIPE - 1)
               finish_test("reset_fill");
         end
         else
         begin
            p = cycle_cnt - PIPE;
            frame = p / FRAME_CYCLES;
            cur_x = p % H_TOTAL;
            cur_y = (p / H_TOTAL) % V_TOTAL;
            // frame 0 still shows the reset digit
            shown = (frame == 0) ? digit_zero : tick_digit[frame - 1];
            check_rgb(rgb, expected_rgb(cur_x, cur_y, shown), "rgb");
            check_sync(hsync, expected_hsync(cur_x), "hsync");
            check_sync(vsync, expected_vsync(cur_y), "vsync");
            if ((p % FRAME_CYCLES) == FRAME_CYCLES - 1)
            begin
               finish_test($sformatf("frame_%0d digit %0d", frame, shown));
               if (frame == NUM_FRAMES - 1)
                  run_done = 1'b1;
            end
         end
      end
   end

   // ----------------------------------------------------------------------
   // stimulus
   // ----------------------------------------------------------------------
   initial
   begin : main_sequence
      int change_at;
      int sprite_line;
      int rand_val;
      seed = 32'h06f44a11;
      reset = 1'b1;
      digit_sel = digit_zero;
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset <= 1'b0;
      // new digit in the middle of the sprite rows of every frame
      for (int f = 0; f < NUM_FRAMES; f++)
      begin
         rand_val = $random(seed) & 32'h7fff_ffff;
         sprite_line = SPR_Y + (rand_val % SPR_H);
         rand_val = $random(seed) & 32'h7fff_ffff;
         change_at = f * FRAME_CYCLES + sprite_line * H_TOTAL + (rand_val % H_VIS);
         while (cycle_cnt < change_at)
            @(negedge clk);
         rand_val = $random(seed) & 32'h7fff_ffff;
         digit_sel <= digit_e'(4'(rand_val % 10));
      end
      wait (run_done);
      $display("summary: %0d checks, %0d errors", total_checks, total_errors);
      if (total_errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

   // hard stop a frame past the expected end
   initial
   begin : watchdog
      #(WATCHDOG_NS);
      $display("timeout: run not finished after %0d ns", WATCHDOG_NS);
      $display("Regression failed");
      $finish;
   end

endmodule

// ==== tb/scoreboard_asserts.sv ====
`timescale 1ns/1ps

`include "vga_macros.svh"

module scoreboard_asserts
   import vga_pkg::*;
(
   input logic clk,
   input logic reset,
   input logic vis,
   input rgb_t color,
   input logic sync_n,
   input logic tick
);

   // ----------------------------------------------------------------------
   // hsync pulse length
   // ----------------------------------------------------------------------
   // consecutive low cycles of the sync seen so far
   logic [9:0] low_len;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         low_len <= '0;
      end
      else if (!sync_n)
      begin
         low_len <= low_len + 10'd1;
      end
      else
      begin
         low_len <= '0;
      end
   end

   // ----------------------------------------------------------------------
   // checks
   // ----------------------------------------------------------------------
   // blank one cycle ahead means black out
   blank_is_black: assert property (@(posedge clk) disable iff (reset)
      !vis |=> (color == '0))
      else $error("color not black outside the visible area");

   tick_one_cycle: assert property (@(posedge clk) disable iff (reset)
      tick |=> !tick)
      else $error("refresh tick wider than one cycle");

   // pulse ends after exactly H_SYNC low cycles
   hsync_width: assert property (@(posedge clk) disable iff (reset)
      $rose(sync_n) |-> (low_len == `H_SYNC))
      else $error("hsync pulse length differs from H_SYNC");

   hsync_not_stuck: assert property (@(posedge clk) disable iff (reset)
      !sync_n |-> (low_len < `H_SYNC))
      else $error("hsync low for more than H_SYNC cycles");

endmodule

// top level sees the output stage and the refresh tick together
bind scoreboard_top scoreboard_asserts u_asserts
(
   .clk    (clk),
   .reset  (reset),
   .vis    (video_on_d),
   .color  (rgb),
   .sync_n (hsync),
   .tick   (refr_tick)
);

// ==== src/scoreboard_top.sv ====
`timescale 1ns/1ps

module scoreboard_top
   import vga_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  digit_e digit_sel,
   output rgb_t   rgb,
   output logic   hsync,
   output logic   vsync
);

   // ----------------------------------------------------------------------
   // stage to stage wires
   // ----------------------------------------------------------------------
   // timing stage outputs, cycle 0
   logic [9:0] pix_x;
   logic [9:0] pix_y;
   logic       video_on;
   logic       hsync_raw;
   logic       vsync_raw;
   logic       refr_tick;

   // glyph stage outputs, cycle 1
   logic       sprite_on;
   logic       video_on_d;
   logic       hsync_d;
   logic       vsync_d;

   // ----------------------------------------------------------------------
   // stages
   // ----------------------------------------------------------------------
   pixel_timing u_timing
   (
      .clk       (clk),
      .reset     (reset),
      .pix_x     (pix_x),
      .pix_y     (pix_y),
      .video_on  (video_on),
      .hsync_raw (hsync_raw),
      .vsync_raw (vsync_raw),
      .refr_tick (refr_tick)
   );

   digit_sprite u_sprite
   (
      .clk        (clk),
      .reset      (reset),
      .pix_x      (pix_x),
      .pix_y      (pix_y),
      .video_on   (video_on),
      .hsync_raw  (hsync_raw),
      .vsync_raw  (vsync_raw),
      .refr_tick  (refr_tick),
      .digit_sel  (digit_sel),
      .sprite_on  (sprite_on),
      .video_on_d (video_on_d),
      .hsync_d    (hsync_d),
      .vsync_d    (vsync_d)
   );

   // registered outputs, cycle 2
   pixel_color u_color
   (
      .clk        (clk),
      .reset      (reset),
      .sprite_on  (sprite_on),
      .video_on_d (video_on_d),
      .hsync_d    (hsync_d),
      .vsync_d    (vsync_d),
      .rgb        (rgb),
      .hsync      (hsync),
      .vsync      (vsync)
   );

endmodule

// ==== src/pixel_color.sv ====
`timescale 1ns/1ps

`include "vga_macros.svh"

module pixel_color
   import vga_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic sprite_on,
   input  logic video_on_d,
   input  logic hsync_d,
   input  logic vsync_d,
   output rgb_t rgb,
   output logic hsync,
   output logic vsync
);

   // ----------------------------------------------------------------------
   // color merge
   // ----------------------------------------------------------------------
   rgb_t rgb_next;

   // blanking wins, then the sprite, then background
   always_comb
   begin
      if (!video_on_d)
      begin
         rgb_next = '0;
      end
      else if (sprite_on)
      begin
         rgb_next = `SPRITE_RGB;
      end
      else
      begin
         rgb_next = `BG_RGB;
      end
   end

   // ----------------------------------------------------------------------
   // output registers
   // ----------------------------------------------------------------------
   // syncs take the same extra cycle as rgb
   // total latency PIPE_DEPTH from the counters
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         rgb   <= '0;
         hsync <= 1'b1;
         vsync <= 1'b1;
      end
      else
      begin
         rgb   <= rgb_next;
         hsync <= hsync_d;
         vsync <= vsync_d;
      end
   end

endmodule

// ==== src/digit_sprite.sv ====
`timescale 1ns/1ps

`include "vga_macros.svh"

module digit_sprite
   import vga_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic [9:0] pix_x,
   input  logic [9:0] pix_y,
   input  logic       video_on,
   input  logic       hsync_raw,
   input  logic       vsync_raw,
   input  logic       refr_tick,
   input  digit_e     digit_sel,
   output logic       sprite_on,
   output logic       video_on_d,
   output logic       hsync_d,
   output logic       vsync_d
);

   // ----------------------------------------------------------------------
   // current digit
   // ----------------------------------------------------------------------
   digit_e cur_digit;

   // sampled once per frame so the glyph never tears
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         cur_digit <= digit_zero;
      end
      else if (refr_tick)
      begin
         cur_digit <= digit_sel;
      end
   end

   // ----------------------------------------------------------------------
   // sprite window and rom address
   // ----------------------------------------------------------------------
   logic       in_window;
   logic [9:0] row_off;
   logic [9:0] col_off;
   logic [3:0] rom_row;
   logic [4:0] rom_col;

   assign in_window = (pix_x >= `SPRITE_X) && (pix_x <= (`SPRITE_X + `SPRITE_W - 10'd1)) &&
                      (pix_y >= `SPRITE_Y) && (pix_y <= (`SPRITE_Y + `SPRITE_H - 10'd1));

   // offsets into the glyph, only meaningful inside the window
   assign row_off = pix_y - `SPRITE_Y;
   assign col_off = pix_x - `SPRITE_X;
   assign rom_row = row_off[3:0];
   assign rom_col = col_off[4:0];

   // ----------------------------------------------------------------------
   // glyph rom
   // ----------------------------------------------------------------------
   // segment order {g, f, e, d, c, b, a}
   logic [6:0]  seg;
   logic        seg_a, seg_b, seg_c, seg_d, seg_e, seg_f, seg_g;
   logic [31:0] rom_data;
   logic        rom_bit;

   always_comb
   begin
      case (cur_digit)
         digit_zero:  seg = 7'b0111111;
         digit_one:   seg = 7'b0000110;
         digit_two:   seg = 7'b1011011;
         digit_three: seg = 7'b1001111;
         digit_four:  seg = 7'b1100110;
         digit_five:  seg = 7'b1101101;
         digit_six:   seg = 7'b1111101;
         digit_seven: seg = 7'b0000111;
         digit_eight: seg = 7'b1111111;
         digit_nine:  seg = 7'b1101111;
         // illegal code, blank glyph
         default:     seg = 7'b0000000;
      endcase
   end

   assign seg_a = seg[0];
   assign seg_b = seg[1];
   assign seg_c = seg[2];
   assign seg_d = seg[3];
   assign seg_e = seg[4];
   assign seg_f = seg[5];
   assign seg_g = seg[6];

   // 16 rows in five bands, bar rows also carry the verticals
   // so the strokes join at the corners
   always_comb
   begin
      case (rom_row)
         // top bar
         4'd0, 4'd1:
            rom_data = ({32{seg_a}} & `GLYPH_BAR) |
                       ({32{seg_f}} & `GLYPH_LEFT) |
                       ({32{seg_b}} & `GLYPH_RIGHT);
         // upper verticals
         4'd2, 4'd3, 4'd4, 4'd5, 4'd6:
            rom_data = ({32{seg_f}} & `GLYPH_LEFT) |
                       ({32{seg_b}} & `GLYPH_RIGHT);
         // middle bar
         4'd7, 4'd8:
            rom_data = ({32{seg_g}} & `GLYPH_BAR) |
                       ({32{seg_f | seg_e}} & `GLYPH_LEFT) |
                       ({32{seg_b | seg_c}} & `GLYPH_RIGHT);
         // lower verticals
         4'd9, 4'd10, 4'd11, 4'd12, 4'd13:
            rom_data = ({32{seg_e}} & `GLYPH_LEFT) |
                       ({32{seg_c}} & `GLYPH_RIGHT);
         // bottom bar, rows 14 and 15
         default:
            rom_data = ({32{seg_d}} & `GLYPH_BAR) |
                       ({32{seg_e}} & `GLYPH_LEFT) |
                       ({32{seg_c}} & `GLYPH_RIGHT);
      endcase
   end

   assign rom_bit = rom_data[rom_col];

   // ----------------------------------------------------------------------
   // stage register
   // ----------------------------------------------------------------------
   // syncs idle high
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         sprite_on  <= 1'b0;
         video_on_d <= 1'b0;
         hsync_d    <= 1'b1;
         vsync_d    <= 1'b1;
      end
      else
      begin
         sprite_on  <= in_window & rom_bit;
         video_on_d <= video_on;
         hsync_d    <= hsync_raw;
         vsync_d    <= vsync_raw;
      end
   end

endmodule

// ==== src/pixel_timing.sv ====
`timescale 1ns/1ps

`include "vga_macros.svh"

module pixel_timing
(
   input  logic       clk,
   input  logic       reset,
   output logic [9:0] pix_x,
   output logic [9:0] pix_y,
   output logic       video_on,
   output logic       hsync_raw,
   output logic       vsync_raw,
   output logic       refr_tick
);

   // ----------------------------------------------------------------------
   // scan counters
   // ----------------------------------------------------------------------
   logic [9:0] h_count;
   logic [9:0] v_count;
   logic       h_end;
   logic       v_end;

   // last pixel of a line, last line of a frame
   assign h_end = (h_count == (`H_TOTAL - 10'd1));
   assign v_end = (v_count == (`V_TOTAL - 10'd1));

   // one clk per pixel, no divider
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         h_count <= '0;
         v_count <= '0;
      end
      else
      begin
         if (h_end)
         begin
            h_count <= '0;
            // line done, step the vertical counter
            if (v_end)
            begin
               v_count <= '0;
            end
            else
            begin
               v_count <= v_count + 10'd1;
            end
         end
         else
         begin
            h_count <= h_count + 10'd1;
         end
      end
   end

   // ----------------------------------------------------------------------
   // decode
   // ----------------------------------------------------------------------
   // coordinates straight from the counters
   assign pix_x = h_count;
   assign pix_y = v_count;

   // visible area only
   assign video_on = (h_count < `H_VISIBLE) && (v_count < `V_VISIBLE);

   // sync pulses, active low
   assign hsync_raw = !((h_count >= `H_SYNC_START) && (h_count <= `H_SYNC_END));
   assign vsync_raw = !((v_count >= `V_SYNC_START) && (v_count <= `V_SYNC_END));

   // once per frame, first pixel of the first blank line
   // comes well after the sprite rows, so a digit swap here is safe
   assign refr_tick = (h_count == 10'd0) && (v_count == `V_VISIBLE);

endmodule

// ==== src/vga_pkg.sv ====
package vga_pkg;

   // ----------------------------------------------------------------------
   // digit codes
   // ----------------------------------------------------------------------
   // 4-bit code, 10 to 15 are illegal
   // the glyph stage draws nothing for an illegal code
   typedef enum logic [3:0]
   {
      digit_zero  = 4'd0,
      digit_one   = 4'd1,
      digit_two   = 4'd2,
      digit_three = 4'd3,
      digit_four  = 4'd4,
      digit_five  = 4'd5,
      digit_six   = 4'd6,
      digit_seven = 4'd7,
      digit_eight = 4'd8,
      digit_nine  = 4'd9
   } digit_e;

   // ----------------------------------------------------------------------
   // pixel color
   // ----------------------------------------------------------------------
   // one bit per gun, packs to {r, g, b}
   // so 3'b101 is magenta and 3'b001 is blue
   typedef struct packed
   {
      logic r;
      logic g;
      logic b;
   } rgb_t;

endpackage

// ==== src/vga_macros.svh ====
`ifndef VGA_MACROS_SVH
`define VGA_MACROS_SVH

// ----------------------------------------------------------------------
// horizontal timing, in pixels
// ----------------------------------------------------------------------
`define H_VISIBLE      10'd640
`define H_FRONT        10'd16
`define H_SYNC         10'd96
`define H_BACK         10'd48
// full line, 800 pixels
`define H_TOTAL        (`H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK)
// first and last pixel of the sync pulse
`define H_SYNC_START   (`H_VISIBLE + `H_FRONT)
`define H_SYNC_END     (`H_SYNC_START + `H_SYNC - 10'd1)

// ----------------------------------------------------------------------
// vertical timing, in lines
// ----------------------------------------------------------------------
`define V_VISIBLE      10'd480
`define V_FRONT        10'd10
`define V_SYNC         10'd2
`define V_BACK         10'd33
// full frame, 525 lines
`define V_TOTAL        (`V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK)
`define V_SYNC_START   (`V_VISIBLE + `V_FRONT)
`define V_SYNC_END     (`V_SYNC_START + `V_SYNC - 10'd1)

// ----------------------------------------------------------------------
// sprite geometry, top left corner and size
// ----------------------------------------------------------------------
`define SPRITE_X       10'd300
`define SPRITE_Y       10'd10
`define SPRITE_W       10'd32
`define SPRITE_H       10'd16

// glyph column masks, bit n is sprite column n
`define GLYPH_BAR      32'h00ff_ff00
`define GLYPH_LEFT     32'h0000_0f00
`define GLYPH_RIGHT    32'h00f0_0000

// ----------------------------------------------------------------------
// colors and pipeline
// ----------------------------------------------------------------------
`define SPRITE_RGB     3'b101
`define BG_RGB         3'b001
// counter registers to output registers
`define PIPE_DEPTH     2

`endif
